// ==== src/dcache_pkg.sv ====
// Data cache shared definitions, bus widths and line states
package dcache_pkg;

  // Byte address width on both buses
  localparam int ADDR_W = 32;

  // Word width on both buses
  localparam int DATA_W = 32;

  // Per-line state
  // INVALID holds nothing usable
  // VALID is clean and matches memory
  // MODIFIED is dirty, written back on eviction
  typedef enum logic [1:0] {
    INVALID  = 2'b00,
    VALID    = 2'b01,
    MODIFIED = 2'b10
  } cache_state_e;

endpackage

// ==== src/line_fifo.sv ====
// Write buffer, circular FIFO of evicted dirty lines with full and empty flags
`timescale 1ns/1ps
module line_fifo #(
  parameter int WIDTH    = 288,
  parameter int WB_DEPTH = 4
) (
  input  logic             clock,
  input  logic             rst,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] head_data,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;
  localparam int CNT_W = $clog2(WB_DEPTH + 1);

  // Entry storage, payload only
  logic [WIDTH-1:0] slots [WB_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap at depth, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(WB_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign full      = (count == CNT_W'(WB_DEPTH));
  assign empty     = (count == '0);
  // Ignore push when full, pop when empty
  assign do_push   = push && !full;
  assign do_pop    = pop && !empty;
  assign head_data = slots[rd_ptr];

  always_ff @(posedge clock) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Occupancy, simultaneous push and pop leave it unchanged
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      slots[wr_ptr] <= push_data;
    end
  end

endmodule

// ==== src/dcache_array.sv ====
// Direct-mapped cache storage, tags, line states and words with combinational lookup
`timescale 1ns/1ps
module dcache_array #(
  parameter int SETS  = 8,
  parameter int WORDS = 8
) (
  input  logic                                clock,
  input  logic                                rst,
  input  logic [dcache_pkg::ADDR_W-1:0]       lookup_adr,
  output logic                                hit,
  output logic                                dirty,
  output logic [dcache_pkg::ADDR_W-1:0]       victim_adr,
  output logic [WORDS*dcache_pkg::DATA_W-1:0] victim_line,
  output logic [dcache_pkg::DATA_W-1:0]       rd_word,
  input  logic                                wr_en,
  input  logic [dcache_pkg::DATA_W-1:0]       wr_word,
  input  logic                                fill_en,
  input  logic                                fill_last,
  input  logic [$clog2(WORDS)-1:0]            fill_idx,
  input  logic [dcache_pkg::DATA_W-1:0]       fill_data
);
  import dcache_pkg::*;

  // Address split: tag | set | word | byte
  localparam int IDX_W = $clog2(WORDS);
  localparam int OFF_W = IDX_W + 2;
  localparam int SET_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - OFF_W - SET_W;

  logic [TAG_W-1:0]             tag_q   [SETS];
  cache_state_e                 state_q [SETS];
  logic [WORDS-1:0][DATA_W-1:0] line_q  [SETS];

  logic [SET_W-1:0] set_sel;
  logic [IDX_W-1:0] word_sel;
  logic [TAG_W-1:0] tag_in;

  assign set_sel  = lookup_adr[OFF_W +: SET_W];
  assign word_sel = lookup_adr[2 +: IDX_W];
  assign tag_in   = lookup_adr[ADDR_W-1 -: TAG_W];

  // Lookup, purely combinational on the selected set
  assign hit   = (state_q[set_sel] != INVALID) && (tag_q[set_sel] == tag_in);
  assign dirty = (state_q[set_sel] == MODIFIED);

  // Victim address rebuilt from the stored tag, line aligned
  assign victim_adr  = {tag_q[set_sel], set_sel, {OFF_W{1'b0}}};
  assign victim_line = line_q[set_sel];
  assign rd_word     = line_q[set_sel][word_sel];

  // Line state
  always_ff @(posedge clock) begin
    if (rst) begin
      for (int s = 0; s < SETS; s++) begin
        state_q[s] <= INVALID;
      end
    end else if (fill_en) begin
      // Partly refilled line stays unusable until its last word
      if (fill_last) begin
        state_q[set_sel] <= VALID;
      end else begin
        state_q[set_sel] <= INVALID;
      end
    end else if (wr_en) begin
      state_q[set_sel] <= MODIFIED;
    end
  end

  // Tags and words
  always_ff @(posedge clock) begin
    if (fill_en) begin
      line_q[set_sel][fill_idx] <= fill_data;
      // New tag only once the whole line has arrived
      if (fill_last) begin
        tag_q[set_sel] <= tag_in;
      end
    end else if (wr_en) begin
      line_q[set_sel][word_sel] <= wr_word;
    end
  end

endmodule

// ==== src/dcache_ctrl.sv ====
// Cache controller, processor-side Wishbone slave and miss handling FSM
`timescale 1ns/1ps
module dcache_ctrl #(
  parameter int SETS  = 8,
  parameter int WORDS = 8
) (
  input  logic                          clock,
  input  logic                          rst,
  input  logic                          cpu_cyc,
  input  logic                          cpu_stb,
  input  logic                          cpu_we,
  input  logic [dcache_pkg::ADDR_W-1:0] cpu_adr,
  input  logic [dcache_pkg::DATA_W-1:0] cpu_dat_w,
  output logic [dcache_pkg::DATA_W-1:0] cpu_dat_r,
  output logic                          cpu_ack,
  output logic [dcache_pkg::ADDR_W-1:0] lookup_adr,
  input  logic                          hit,
  input  logic                          dirty,
  input  logic [dcache_pkg::DATA_W-1:0] rd_word,
  output logic                          wr_en,
  output logic [dcache_pkg::DATA_W-1:0] wr_word,
  output logic                          push,
  input  logic                          full,
  output logic                          refill_req,
  output logic [dcache_pkg::ADDR_W-1:0] refill_adr,
  input  logic                          refill_done
);
  import dcache_pkg::*;

  localparam int OFF_W = $clog2(WORDS) + 2;
  localparam int SET_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - OFF_W - SET_W;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    EVICT,
    REFILL,
    RESPOND
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        req;

  assign req = cpu_cyc && cpu_stb;

  // Master holds the address until ack, so it drives lookup directly
  assign lookup_adr = cpu_adr;
  assign refill_adr = {cpu_adr[ADDR_W-1 -: TAG_W], cpu_adr[OFF_W +: SET_W], {OFF_W{1'b0}}};

  // Ack one cycle after sampling on a hit
  // or right after the refill, when the line is certain to hit
  assign cpu_ack   = req && (((state_q == LOOKUP) && hit) || (state_q == RESPOND));
  assign cpu_dat_r = rd_word;

  // Stores land in the cycle of their ack, hit or write-allocate
  assign wr_en   = cpu_ack && cpu_we;
  assign wr_word = cpu_dat_w;

  // Victim goes out only when the buffer has room
  assign push       = (state_q == EVICT) && !full;
  // Held until mem_port answers
  assign refill_req = (state_q == REFILL);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (!req || hit) begin
          state_d = IDLE;
        end else if (dirty) begin
          state_d = EVICT;
        end else begin
          state_d = REFILL;
        end
      end
      EVICT: begin
        if (!full) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (refill_done) begin
          state_d = RESPOND;
        end
      end
      RESPOND: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== src/mem_port.sv ====
// Memory-side Wishbone master, drains the write buffer and refills lines
`timescale 1ns/1ps
module mem_port #(
  parameter int WORDS = 8,
  parameter int WIDTH = dcache_pkg::ADDR_W + WORDS * dcache_pkg::DATA_W
) (
  input  logic                          clock,
  input  logic                          rst,
  output logic                          mem_cyc,
  output logic                          mem_stb,
  output logic                          mem_we,
  output logic [dcache_pkg::ADDR_W-1:0] mem_adr,
  output logic [dcache_pkg::DATA_W-1:0] mem_dat_w,
  input  logic [dcache_pkg::DATA_W-1:0] mem_dat_r,
  input  logic                          mem_ack,
  input  logic                          empty,
  input  logic [WIDTH-1:0]              head_data,
  output logic                          pop,
  input  logic                          refill_req,
  input  logic [dcache_pkg::ADDR_W-1:0] refill_adr,
  output logic                          refill_done,
  output logic                          fill_en,
  output logic [$clog2(WORDS)-1:0]      fill_idx,
  output logic [dcache_pkg::DATA_W-1:0] fill_data,
  output logic                          fill_last
);
  import dcache_pkg::*;

  localparam int IDX_W = $clog2(WORDS);
  localparam int OFF_W = IDX_W + 2;

  typedef enum logic [1:0] {
    M_IDLE,
    M_DRAIN,
    M_REFILL
  } port_mode_e;

  port_mode_e        mode_q;
  logic [IDX_W-1:0]  cnt_q;
  logic              xfer;
  logic              last_word;
  logic [ADDR_W-1:0] head_adr;
  logic [ADDR_W-1:0] base_adr;

  // Buffer entry is {line address, line words}, word 0 at the bottom
  assign head_adr  = head_data[WIDTH-1 -: ADDR_W];
  assign base_adr  = (mode_q == M_DRAIN) ? head_adr : refill_adr;
  assign xfer      = mem_cyc && mem_ack;
  assign last_word = (cnt_q == IDX_W'(WORDS - 1));

  // Bus outputs follow registered mode and counter, steady until ack
  assign mem_cyc   = (mode_q != M_IDLE);
  assign mem_stb   = mem_cyc;
  assign mem_we    = (mode_q == M_DRAIN);
  assign mem_adr   = {base_adr[ADDR_W-1:OFF_W], cnt_q, 2'b00};
  assign mem_dat_w = head_data[cnt_q*DATA_W +: DATA_W];

  // Head entry released once its last word is acknowledged
  assign pop       = mem_we && xfer && last_word;

  // Refill words go straight into the array
  assign fill_en   = (mode_q == M_REFILL) && xfer;
  assign fill_idx  = cnt_q;
  assign fill_data = mem_dat_r;
  assign fill_last = fill_en && last_word;

  always_ff @(posedge clock) begin
    if (rst) begin
      mode_q      <= M_IDLE;
      cnt_q       <= '0;
      refill_done <= 1'b0;
    end else begin
      refill_done <= fill_last;
      case (mode_q)
        M_IDLE: begin
          // Drain first, refill only from an empty buffer
          // refill_done guard keeps a finished request from restarting
          if (!empty) begin
            mode_q <= M_DRAIN;
          end else if (refill_req && !refill_done) begin
            mode_q <= M_REFILL;
          end
        end
        default: begin
          if (xfer) begin
            if (last_word) begin
              cnt_q  <= '0;
              mode_q <= M_IDLE;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== src/data_cache.sv ====
// Data cache top, write-back write-allocate with a line write buffer
`timescale 1ns/1ps
module data_cache #(
  parameter int SETS     = 8,
  parameter int WORDS    = 8,
  parameter int WB_DEPTH = 4
) (
  input  logic                          clock,
  input  logic                          rst,
  input  logic                          cpu_cyc,
  input  logic                          cpu_stb,
  input  logic                          cpu_we,
  input  logic [dcache_pkg::ADDR_W-1:0] cpu_adr,
  input  logic [dcache_pkg::DATA_W-1:0] cpu_dat_w,
  output logic [dcache_pkg::DATA_W-1:0] cpu_dat_r,
  output logic                          cpu_ack,
  output logic                          mem_cyc,
  output logic                          mem_stb,
  output logic                          mem_we,
  output logic [dcache_pkg::ADDR_W-1:0] mem_adr,
  output logic [dcache_pkg::DATA_W-1:0] mem_dat_w,
  input  logic [dcache_pkg::DATA_W-1:0] mem_dat_r,
  input  logic                          mem_ack
);
  import dcache_pkg::*;

  // Buffer entry, line address over line words
  localparam int WB_W = ADDR_W + WORDS * DATA_W;

  // Controller and array
  logic [ADDR_W-1:0]       lookup_adr;
  logic                    hit;
  logic                    dirty;
  logic [ADDR_W-1:0]       victim_adr;
  logic [WORDS*DATA_W-1:0] victim_line;
  logic [DATA_W-1:0]       rd_word;
  logic                    wr_en;
  logic [DATA_W-1:0]       wr_word;

  // Write buffer
  logic                    push;
  logic                    pop;
  logic                    full;
  logic                    empty;
  logic [WB_W-1:0]         head_data;

  // Refill path
  logic                    refill_req;
  logic [ADDR_W-1:0]       refill_adr;
  logic                    refill_done;
  logic                    fill_en;
  logic                    fill_last;
  logic [$clog2(WORDS)-1:0] fill_idx;
  logic [DATA_W-1:0]       fill_data;

  dcache_array #(
    .SETS (SETS),
    .WORDS(WORDS)
  ) u_array (
    .clock      (clock),
    .rst        (rst),
    .lookup_adr (lookup_adr),
    .hit        (hit),
    .dirty      (dirty),
    .victim_adr (victim_adr),
    .victim_line(victim_line),
    .rd_word    (rd_word),
    .wr_en      (wr_en),
    .wr_word    (wr_word),
    .fill_en    (fill_en),
    .fill_last  (fill_last),
    .fill_idx   (fill_idx),
    .fill_data  (fill_data)
  );

  dcache_ctrl #(
    .SETS (SETS),
    .WORDS(WORDS)
  ) u_ctrl (
    .clock      (clock),
    .rst        (rst),
    .cpu_cyc    (cpu_cyc),
    .cpu_stb    (cpu_stb),
    .cpu_we     (cpu_we),
    .cpu_adr    (cpu_adr),
    .cpu_dat_w  (cpu_dat_w),
    .cpu_dat_r  (cpu_dat_r),
    .cpu_ack    (cpu_ack),
    .lookup_adr (lookup_adr),
    .hit        (hit),
    .dirty      (dirty),
    .rd_word    (rd_word),
    .wr_en      (wr_en),
    .wr_word    (wr_word),
    .push       (push),
    .full       (full),
    .refill_req (refill_req),
    .refill_adr (refill_adr),
    .refill_done(refill_done)
  );

  line_fifo #(
    .WIDTH   (WB_W),
    .WB_DEPTH(WB_DEPTH)
  ) u_wbuf (
    .clock    (clock),
    .rst      (rst),
    .push     (push),
    .push_data({victim_adr, victim_line}),
    .pop      (pop),
    .head_data(head_data),
    .full     (full),
    .empty    (empty)
  );

  mem_port #(
    .WORDS(WORDS),
    .WIDTH(WB_W)
  ) u_mem (
    .clock      (clock),
    .rst        (rst),
    .mem_cyc    (mem_cyc),
    .mem_stb    (mem_stb),
    .mem_we     (mem_we),
    .mem_adr    (mem_adr),
    .mem_dat_w  (mem_dat_w),
    .mem_dat_r  (mem_dat_r),
    .mem_ack    (mem_ack),
    .empty      (empty),
    .head_data  (head_data),
    .pop        (pop),
    .refill_req (refill_req),
    .refill_adr (refill_adr),
    .refill_done(refill_done),
    .fill_en    (fill_en),
    .fill_idx   (fill_idx),
    .fill_data  (fill_data),
    .fill_last  (fill_last)
  );

endmodule

// ==== tests/clock_gen.sv ====
// Testbench clock and reset source, free-running clock with reset held for a few cycles
`timescale 1ns/1ps
module clock_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 3
) (
  output logic clock,
  output logic rst
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // Reset released on a falling edge, away from the sampling edge
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
  end

endmodule

// ==== tests/mem_model.sv ====
// Wishbone classic memory slave, single-cycle ack after strobe, preloaded pattern
`timescale 1ns/1ps
module mem_model #(
  parameter int MEM_WORDS = 1024
) (
  input  logic        clock,
  input  logic        rst,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [31:0] dat_w,
  output logic [31:0] dat_r,
  output logic        ack
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [31:0]      mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;

  assign idx = adr[IDX_W+1:2];

  // Each word starts as its byte address mixed with a marker
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'(i * 4) ^ 32'h5a5a0000;
    end
  end

  // Ack one cycle after strobe, then drop for a cycle before the next word
  always_ff @(posedge clock) begin
    if (rst) begin
      ack   <= 1'b0;
      dat_r <= '0;
    end else begin
      ack <= cyc && stb && !ack;
      if (cyc && stb && !ack) begin
        dat_r <= mem[idx];
        if (we) begin
          mem[idx] <= dat_w;
        end
      end
    end
  end

endmodule

// ==== tests/dcache_checker.sv ====
// Protocol assertions on the processor and memory Wishbone buses of the data cache
`timescale 1ns/1ps
module dcache_checker (
  input logic        clock,
  input logic        rst,
  input logic        cpu_cyc,
  input logic        cpu_stb,
  input logic        cpu_ack,
  input logic        mem_cyc,
  input logic        mem_stb,
  input logic        mem_ack,
  input logic [31:0] mem_adr
);

  // Failures so far, read by the testbench at the end
  int err_count = 0;

  // Ack only inside an active processor cycle whose request was already sampled
  cpu_ack_in_cycle: assert property (@(posedge clock) disable iff (rst)
    cpu_ack |-> (cpu_cyc && cpu_stb && $past(cpu_cyc && cpu_stb)))
    else begin
      err_count++;
      $error("cpu_ack raised outside its cycle or before the request was sampled");
    end

  // Single-cycle ack pulse
  cpu_ack_pulse: assert property (@(posedge clock) disable iff (rst)
    cpu_ack |=> !cpu_ack)
    else begin
      err_count++;
      $error("cpu_ack held high for two cycles");
    end

  // Strobe waits for the slave
  mem_stb_hold: assert property (@(posedge clock) disable iff (rst)
    (mem_stb && !mem_ack) |=> mem_stb)
    else begin
      err_count++;
      $error("mem_stb dropped before mem_ack");
    end

  // Address steady while waiting
  mem_adr_hold: assert property (@(posedge clock) disable iff (rst)
    (mem_stb && !mem_ack) |=> $stable(mem_adr))
    else begin
      err_count++;
      $error("mem_adr changed while mem_stb waited for mem_ack");
    end

  // No memory cycle while reset is held
  mem_idle_in_reset: assert property (@(posedge clock)
    (rst && $past(rst)) |-> !mem_cyc)
    else begin
      err_count++;
      $error("mem_cyc high during reset");
    end

endmodule

// ==== tests/data_cache_tb.sv ====
// Data cache testbench, table of operations plus a random tail against a shadow memory
`timescale 1ns/1ps
module data_cache_tb;

  localparam int SETS      = 8;
  localparam int WORDS     = 8;
  localparam int WB_DEPTH  = 4;
  localparam int NUM_OPS   = 24;
  localparam int TAIL_OPS  = 24;
  localparam int MEM_WORDS = 1024;
  // Worst-case miss budget per operation
  localparam int LIMIT     = (NUM_OPS + TAIL_OPS) * (3 * WORDS + 12);

  typedef struct packed {
    logic        we;
    logic        hit;
    logic [31:0] adr;
    logic [31:0] dat;
  } op_t;

  logic        clock;
  logic        rst;
  logic        cpu_cyc;
  logic        cpu_stb;
  logic        cpu_we;
  logic [31:0] cpu_adr;
  logic [31:0] cpu_dat_w;
  logic [31:0] cpu_dat_r;
  logic        cpu_ack;
  logic        mem_cyc;
  logic        mem_stb;
  logic        mem_we;
  logic [31:0] mem_adr;
  logic [31:0] mem_dat_w;
  logic [31:0] mem_dat_r;
  logic        mem_ack;

  op_t         ops [NUM_OPS];
  logic [31:0] shadow [MEM_WORDS];
  int          cycle_cnt = 0;

  clock_gen #(.PERIOD_NS(8), .RST_CYCLES(3)) u_clk (.clock(clock), .rst(rst));

  mem_model #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clock(clock), .rst(rst), .cyc(mem_cyc), .stb(mem_stb), .we(mem_we),
    .adr(mem_adr), .dat_w(mem_dat_w), .dat_r(mem_dat_r), .ack(mem_ack)
  );

  data_cache #(.SETS(SETS), .WORDS(WORDS), .WB_DEPTH(WB_DEPTH)) UUT (
    .clock(clock), .rst(rst),
    .cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we), .cpu_adr(cpu_adr),
    .cpu_dat_w(cpu_dat_w), .cpu_dat_r(cpu_dat_r), .cpu_ack(cpu_ack),
    .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
    .mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r), .mem_ack(mem_ack)
  );

  bind data_cache dcache_checker u_checker (
    .clock(clock), .rst(rst), .cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_ack(cpu_ack),
    .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_ack(mem_ack), .mem_adr(mem_adr)
  );

  // Run limit
  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("Timeout: no cpu_ack after %0d cycles", cycle_cnt);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  // One Wishbone classic transfer, driven and sampled on falling edges
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata, output int cycles);
    @(negedge clock);
    cpu_cyc   = 1'b1;
    cpu_stb   = 1'b1;
    cpu_we    = we;
    cpu_adr   = adr;
    cpu_dat_w = dat;
    cycles    = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!cpu_ack);
    rdata = cpu_dat_r;
    // Strobe drops in the cycle after ack
    @(negedge clock);
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we  = 1'b0;
  endtask

  task automatic apply_op(input op_t op);
    logic [31:0] rdata;
    int          cycles;
    bus_cycle(op.we, op.adr, op.dat, rdata, cycles);
    if (op.hit) begin
      check_eq("cpu_ack latency", 32'(cycles), 32'd1);
    end
    if (op.we) begin
      shadow[op.adr[11:2]] = op.dat;
    end else begin
      check_eq("cpu_dat_r", rdata, shadow[op.adr[11:2]]);
    end
  endtask

  initial begin
    op_t rnd;
    void'($urandom(32'h223cb78e));
    cpu_cyc   = 1'b0;
    cpu_stb   = 1'b0;
    cpu_we    = 1'b0;
    cpu_adr   = '0;
    cpu_dat_w = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = 32'(i * 4) ^ 32'h5a5a0000;
    end
    // we, hit expected, address, write data
    ops = '{
      '{1'b0, 1'b0, 32'h040, 32'h0},         // cold read, refill
      '{1'b0, 1'b1, 32'h040, 32'h0},         // same word, one-cycle hit
      '{1'b0, 1'b1, 32'h044, 32'h0},
      '{1'b1, 1'b1, 32'h048, 32'hdead0001},  // write hit
      '{1'b0, 1'b1, 32'h048, 32'h0},
      '{1'b1, 1'b0, 32'h360, 32'hdead0002},  // write-allocate miss
      '{1'b0, 1'b1, 32'h360, 32'h0},
      '{1'b0, 1'b0, 32'h460, 32'h0},         // conflict, dirty eviction
      '{1'b0, 1'b0, 32'h360, 32'h0},         // back through memory
      '{1'b1, 1'b0, 32'h000, 32'hc0de0000},
      '{1'b1, 1'b0, 32'h020, 32'hc0de0001},
      '{1'b1, 1'b0, 32'h080, 32'hc0de0002},
      '{1'b1, 1'b0, 32'h0a0, 32'hc0de0003},
      '{1'b1, 1'b0, 32'h104, 32'hc0de0004},  // eviction burst starts
      '{1'b1, 1'b0, 32'h124, 32'hc0de0005},
      '{1'b1, 1'b0, 32'h184, 32'hc0de0006},
      '{1'b1, 1'b0, 32'h1a4, 32'hc0de0007},
      '{1'b1, 1'b0, 32'h208, 32'hc0de0008},
      '{1'b0, 1'b0, 32'h000, 32'h0},
      '{1'b0, 1'b0, 32'h020, 32'h0},
      '{1'b0, 1'b0, 32'h080, 32'h0},
      '{1'b0, 1'b0, 32'h0a0, 32'h0},
      '{1'b0, 1'b0, 32'h104, 32'h0},
      '{1'b0, 1'b0, 32'h208, 32'h0}
    };
    @(negedge clock);
    while (rst) @(negedge clock);
    for (int i = 0; i < NUM_OPS; i++) begin
      apply_op(ops[i]);
    end
    // Random tail, eight tags over four sets
    for (int i = 0; i < TAIL_OPS; i++) begin
      rnd.we  = ($urandom_range(0, 1) == 1);
      rnd.hit = 1'b0;
      rnd.adr = ($urandom_range(0, 7) << 8) | ($urandom_range(0, 3) << 5)
              | ($urandom_range(0, 7) << 2);
      rnd.dat = $urandom();
      apply_op(rnd);
    end
    if (UUT.u_checker.err_count != 0) begin
      $display("Bus protocol assertions failed %0d times", UUT.u_checker.err_count);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
src/dcache_pkg.sv
src/line_fifo.sv
src/dcache_array.sv
src/dcache_ctrl.sv
src/mem_port.sv
src/data_cache.sv
tests/clock_gen.sv
tests/mem_model.sv
tests/dcache_checker.sv
tests/data_cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator, fail status on a failing log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module data_cache_tb -Mdir obj_dir -f verilog.f \
  && ./obj_dir/Vdata_cache_tb > sim.log 2>&1 \
  || echo "Simulation finished: FAIL" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0
